/* bg_fetcher.sv */
`timescale 1ns/1ps
`default_nettype none

module bg_fetcher #(
  parameter int SCREEN_W = 32
) (
  input  logic               clk,
  input  logic               reset,
  input  ppu_pkg::ppu_mode_t mode,
  input  logic [7:0]         ly,
  input  logic [7:0]         scx,
  input  logic [7:0]         scy,
  output logic [12:0]        rd_addr,
  input  logic [7:0]         rd_data,
  fifo_push_if.fetcher       push
);
  import ppu_pkg::*;

  // One extra tile covers the fine-scroll pixels
  localparam int TILES = SCREEN_W / 8 + 1;
  localparam int CNT_W = $clog2(TILES + 1);

  typedef enum logic [2:0] {
    F_IDLE,
    F_MAP_ADDR,
    F_MAP_DATA,
    F_LO_ADDR,
    F_LO_DATA,
    F_HI_ADDR,
    F_HI_DATA,
    F_PUSH
  } fetch_state_t;

  fetch_state_t     state;
  logic [4:0]       tile_col;
  logic [CNT_W-1:0] tiles_left;
  logic [7:0]       tile_num;
  logic [7:0]       lo_byte;
  logic [7:0]       hi_byte;
  logic [7:0]       bg_y;

  assign bg_y = ly + scy;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state      <= F_IDLE;
      tile_col   <= 5'd0;
      tiles_left <= '0;
    end else if (mode != mode_transfer) begin
      state <= F_IDLE;
    end else if (push.flush) begin
      // Line start, coarse scroll picks the first column
      state      <= F_MAP_ADDR;
      tile_col   <= scx[7:3];
      tiles_left <= CNT_W'(TILES);
    end else begin
      case (state)
        F_MAP_ADDR: state <= F_MAP_DATA;
        F_MAP_DATA: state <= F_LO_ADDR;
        F_LO_ADDR:  state <= F_LO_DATA;
        F_LO_DATA:  state <= F_HI_ADDR;
        F_HI_ADDR:  state <= F_HI_DATA;
        F_HI_DATA:  state <= F_PUSH;
        F_PUSH: begin
          if (push.has_room) begin
            tile_col   <= tile_col + 5'd1;
            tiles_left <= tiles_left - 1'b1;
            state      <= (tiles_left == CNT_W'(1)) ? F_IDLE : F_MAP_ADDR;
          end
        end
        default: state <= F_IDLE;
      endcase
    end
  end

  // Capture RAM data the clock after each address step
  always_ff @(posedge clk) begin
    case (state)
      F_MAP_DATA: tile_num <= rd_data;
      F_LO_DATA:  lo_byte  <= rd_data;
      F_HI_DATA:  hi_byte  <= rd_data;
      default: ;
    endcase
  end

  always_comb begin
    rd_addr = 13'd0;
    case (state)
      F_MAP_ADDR: rd_addr = TILE_MAP_BASE + {3'b000, bg_y[7:3], tile_col};
      F_LO_ADDR:  rd_addr = {1'b0, tile_num, bg_y[2:0], 1'b0};
      F_HI_ADDR:  rd_addr = {1'b0, tile_num, bg_y[2:0], 1'b1};
      default: ;
    endcase
  end

  // Bit 7 of each byte is the leftmost pixel
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      push.push_row[15 - 2*i -: 2] = {hi_byte[7 - i], lo_byte[7 - i]};
    end
  end

  assign push.push_en = (state == F_PUSH) && push.has_room;

endmodule

`default_nettype wire

/* fifo_push_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface fifo_push_if;
  import ppu_pkg::*;

  logic     push_en;
  pix_row_t push_row;
  // At least eight free slots
  logic     has_room;
  // Clears the FIFO at line start
  logic     flush;

  modport fetcher (
    output push_en,
    output push_row,
    input  has_room,
    input  flush
  );

  modport fifo (
    input  push_en,
    input  push_row,
    input  flush,
    output has_room
  );

endinterface

`default_nettype wire

/* pixel_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_fifo (
  input  logic                clk,
  input  logic                reset,
  fifo_push_if.fifo           push,
  input  logic                pop_en,
  output ppu_pkg::color_idx_t pop_px,
  output logic                empty
);
  import ppu_pkg::*;

  color_idx_t mem [16];
  logic [3:0] wr_ptr;
  logic [3:0] rd_ptr;
  logic [4:0] count;
  logic       do_push;
  logic       do_pop;

  // Stale pixels are hidden while the flush is in progress
  assign empty         = (count == 5'd0) || push.flush;
  assign push.has_room = (count <= 5'd8);
  assign do_push       = push.push_en && !push.flush;
  assign do_pop        = pop_en && !empty;
  assign pop_px        = mem[rd_ptr];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= 4'd0;
      rd_ptr <= 4'd0;
      count  <= 5'd0;
    end else if (push.flush) begin
      wr_ptr <= 4'd0;
      rd_ptr <= 4'd0;
      count  <= 5'd0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 4'd8;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 4'd1;
      end
      count <= count + (do_push ? 5'd8 : 5'd0) - (do_pop ? 5'd1 : 5'd0);
    end
  end

  // Whole row lands in one clock
  always_ff @(posedge clk) begin
    if (do_push) begin
      for (int i = 0; i < 8; i++) begin
        mem[wr_ptr + 4'(i)] <= push.push_row[15 - 2*i -: 2];
      end
    end
  end

endmodule

`default_nettype wire

/* pixel_out.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_out #(
  parameter int SCREEN_W = 32
) (
  input  logic                clk,
  input  logic                reset,
  input  ppu_pkg::ppu_mode_t  mode,
  input  logic [7:0]          ly,
  input  logic [7:0]          scx,
  input  logic [7:0]          bgp,
  input  logic                bg_enable,
  input  logic                empty,
  input  ppu_pkg::color_idx_t pop_px,
  output logic                pop_en,
  output logic                pix_valid,
  output logic [7:0]          pix_x,
  output logic [7:0]          pix_y,
  output logic [1:0]          pix_color,
  output logic                line_done
);
  import ppu_pkg::*;

  localparam logic [7:0] LINE_W = 8'(SCREEN_W);
  localparam logic [7:0] LAST_X = 8'(SCREEN_W - 1);

  logic [2:0] drop_cnt;
  logic [7:0] out_x;
  logic       keep;
  color_idx_t idx;

  // Stop popping once the line is complete
  assign pop_en = (mode == mode_transfer) && !empty && (out_x < LINE_W);
  assign keep   = pop_en && (drop_cnt == scx[2:0]);
  assign idx    = bg_enable ? pop_px : color_idx_t'(2'd0);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      drop_cnt  <= 3'd0;
      out_x     <= 8'd0;
      pix_valid <= 1'b0;
      line_done <= 1'b0;
    end else begin
      pix_valid <= keep;
      line_done <= keep && (out_x == LAST_X);
      if (mode != mode_transfer) begin
        drop_cnt <= 3'd0;
        out_x    <= 8'd0;
      end else if (pop_en) begin
        // Fine scroll discards the first SCX mod 8 pixels
        if (drop_cnt != scx[2:0]) begin
          drop_cnt <= drop_cnt + 3'd1;
        end else begin
          out_x <= out_x + 8'd1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (keep) begin
      pix_x     <= out_x;
      pix_y     <= ly;
      pix_color <= bgp[{idx, 1'b0} +: 2];
    end
  end

endmodule

`default_nettype wire

/* ppu_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module ppu_asserts (
  input logic               clk,
  input logic               reset,
  input ppu_pkg::ppu_mode_t mode,
  input logic               frame_done,
  input logic               pix_valid,
  input logic               push_en,
  input logic               flush,
  input logic               pop_en,
  input logic               empty
);
  import ppu_pkg::*;

  // FIFO fill level rebuilt from the push, pop and flush strobes
  logic [5:0] fill;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      fill <= 6'd0;
    end else if (flush) begin
      fill <= 6'd0;
    end else begin
      fill <= fill + (push_en ? 6'd8 : 6'd0) - ((pop_en && !empty) ? 6'd1 : 6'd0);
    end
  end

  // Pixels leave the pipeline only during transfer
  pix_valid_in_transfer: assert property (
    @(posedge clk) disable iff (reset) pix_valid |-> (mode == mode_transfer)
  ) else $error("pix_valid outside mode 3");

  frame_done_single: assert property (
    @(posedge clk) disable iff (reset) frame_done |=> !frame_done
  ) else $error("frame_done held longer than one clock");

  // A row needs eight free slots when it lands
  push_needs_room: assert property (
    @(posedge clk) disable iff (reset) push_en |-> (fill <= 6'd8)
  ) else $error("row pushed while FIFO had no room");

  // Transfer must hand over to hblank, never run into the line wrap
  transfer_ends_in_line: assert property (
    @(posedge clk) disable iff (reset)
      (mode == mode_transfer) |=> (mode inside {mode_transfer, mode_hblank})
  ) else $error("mode 3 still active at the last dot of the line");

endmodule

bind ppu_top ppu_asserts ppu_asserts_inst (
  .clk        (clk),
  .reset      (reset),
  .mode       (mode),
  .frame_done (frame_done),
  .pix_valid  (pix_valid),
  .push_en    (push_if.push_en),
  .flush      (push_if.flush),
  .pop_en     (pop_en),
  .empty      (empty)
);

`default_nettype wire

/* ppu_pkg.sv */
`default_nettype none

package ppu_pkg;

  // ==============================
  // Display modes
  // ==============================

  // Encoding matches the STAT mode field
  typedef enum logic [1:0] {
    mode_hblank   = 2'd0,
    mode_vblank   = 2'd1,
    mode_oam_scan = 2'd2,
    mode_transfer = 2'd3
  } ppu_mode_t;

  // ==============================
  // Pixel types
  // ==============================

  // Color index before palette lookup
  typedef logic [1:0] color_idx_t;

  // Eight pixels, leftmost pixel in bits 15:14
  typedef logic [15:0] pix_row_t;

  // ==============================
  // Address map
  // ==============================

  localparam logic [15:0] LCDC_ADDR = 16'hFF40;
  localparam logic [15:0] STAT_ADDR = 16'hFF41;
  localparam logic [15:0] SCY_ADDR  = 16'hFF42;
  localparam logic [15:0] SCX_ADDR  = 16'hFF43;
  localparam logic [15:0] LY_ADDR   = 16'hFF44;
  localparam logic [15:0] LYC_ADDR  = 16'hFF45;
  localparam logic [15:0] BGP_ADDR  = 16'hFF47;

  localparam logic [15:0] VRAM_BASE = 16'h8000;
  localparam int          VRAM_SIZE = 8192;

  // 32 x 32 tile map, offset inside VRAM
  localparam logic [12:0] TILE_MAP_BASE = 13'h1800;

endpackage

`default_nettype wire

/* ppu_regs_vram.sv */
`timescale 1ns/1ps
`default_nettype none

module ppu_regs_vram (
  input  logic               clk,
  input  logic               reset,
  input  logic [15:0]        cpu_addr,
  input  logic [7:0]         cpu_wdata,
  input  logic               cpu_we,
  input  logic               cpu_re,
  output logic [7:0]         cpu_rdata,
  input  ppu_pkg::ppu_mode_t mode,
  input  logic [7:0]         ly,
  output logic [7:0]         scx,
  output logic [7:0]         scy,
  output logic [7:0]         bgp,
  output logic               bg_enable,
  input  logic [12:0]        rd_addr,
  output logic [7:0]         rd_data
);
  import ppu_pkg::*;

  localparam logic [15:0] VRAM_LAST = VRAM_BASE + 16'(VRAM_SIZE - 1);

  logic [7:0]  vram [VRAM_SIZE];
  logic [7:0]  lcdc;
  logic [7:0]  lyc;
  logic        in_vram;
  logic        vram_locked;
  logic [12:0] vram_off;

  assign in_vram     = (cpu_addr >= VRAM_BASE) && (cpu_addr <= VRAM_LAST);
  assign vram_locked = (mode == mode_transfer);
  assign vram_off    = 13'(cpu_addr - VRAM_BASE);
  assign bg_enable   = lcdc[0];

  // ==============================
  // CPU writes
  // ==============================

  // LY and STAT are read-only here
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      lcdc <= 8'h91;
      scy  <= 8'h00;
      scx  <= 8'h00;
      lyc  <= 8'h00;
      bgp  <= 8'hE4;
    end else if (cpu_we) begin
      case (cpu_addr)
        LCDC_ADDR: lcdc <= cpu_wdata;
        SCY_ADDR:  scy  <= cpu_wdata;
        SCX_ADDR:  scx  <= cpu_wdata;
        LYC_ADDR:  lyc  <= cpu_wdata;
        BGP_ADDR:  bgp  <= cpu_wdata;
        default: ;
      endcase
    end
  end

  // Fetcher owns VRAM during pixel transfer
  always_ff @(posedge clk) begin
    if (cpu_we && in_vram && !vram_locked) begin
      vram[vram_off] <= cpu_wdata;
    end
  end

  // ==============================
  // CPU reads
  // ==============================

  always_comb begin
    cpu_rdata = 8'hFF;
    if (cpu_re) begin
      if (in_vram) begin
        if (!vram_locked) begin
          cpu_rdata = vram[vram_off];
        end
      end else begin
        case (cpu_addr)
          LCDC_ADDR: cpu_rdata = lcdc;
          STAT_ADDR: cpu_rdata = {5'b00000, (ly == lyc), mode};
          SCY_ADDR:  cpu_rdata = scy;
          SCX_ADDR:  cpu_rdata = scx;
          LY_ADDR:   cpu_rdata = ly;
          LYC_ADDR:  cpu_rdata = lyc;
          BGP_ADDR:  cpu_rdata = bgp;
          default:   cpu_rdata = 8'hFF;
        endcase
      end
    end
  end

  // Fetcher port, one clock latency
  always_ff @(posedge clk) begin
    rd_data <= vram[rd_addr];
  end

endmodule

`default_nettype wire

/* ppu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ppu_tb;
  import ppu_pkg::*;

  localparam int SCREEN_W      = 32;
  localparam int SCREEN_H      = 16;
  localparam int DOTS_PER_LINE = 128;
  localparam int VBLANK_LINES  = 2;
  localparam int FRAME_CYCLES  = (SCREEN_H + VBLANK_LINES) * DOTS_PER_LINE;
  localparam int LAST_LINE     = SCREEN_H + VBLANK_LINES - 1;
  localparam int WAIT_LIMIT    = 5000;
  localparam int FRAME_LIMIT   = 2 * FRAME_CYCLES;

  logic        clk;
  logic        reset;
  logic [15:0] cpu_addr;
  logic [7:0]  cpu_wdata;
  logic        cpu_we;
  logic        cpu_re;
  logic [7:0]  cpu_rdata;
  ppu_mode_t   mode;
  logic [7:0]  ly;
  logic        frame_done;
  logic        pix_valid;
  logic [7:0]  pix_x;
  logic [7:0]  pix_y;
  logic [1:0]  pix_color;

  // Model of VRAM and the registers that shape the image
  logic [7:0]  vram_model [VRAM_SIZE];
  logic [7:0]  exp_scx;
  logic [7:0]  exp_scy;
  logic [7:0]  exp_bgp;
  logic [7:0]  exp_lcdc;
  int          line_cnt [SCREEN_H];
  int          pix_seen;
  logic        cmp_on;
  string       test_name;
  int          err_count;
  logic [7:0]  snap_ly;
  ppu_mode_t   snap_mode;

  ppu_top ppu_top_inst (
    .clk        (clk),
    .reset      (reset),
    .cpu_addr   (cpu_addr),
    .cpu_wdata  (cpu_wdata),
    .cpu_we     (cpu_we),
    .cpu_re     (cpu_re),
    .cpu_rdata  (cpu_rdata),
    .mode       (mode),
    .ly         (ly),
    .frame_done (frame_done),
    .pix_valid  (pix_valid),
    .pix_x      (pix_x),
    .pix_y      (pix_y),
    .pix_color  (pix_color)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ==============================
  // Checking helpers
  // ==============================

  task automatic stop_run();
    $display("Some tests failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      err_count++;
      $display("FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
      stop_run();
    end
  endtask

  // Background color at screen (x, y) from the tile rules
  function automatic logic [1:0] expected_color(input int x, input int y);
    logic [7:0] bx;
    logic [7:0] by;
    logic [7:0] tile;
    logic [7:0] lo;
    logic [7:0] hi;
    logic [1:0] idx;
    int         map_off;
    int         row_off;
    int         bit_pos;
    bx      = 8'(x + exp_scx);
    by      = 8'(y + exp_scy);
    map_off = 'h1800 + int'(by >> 3) * 32 + int'(bx >> 3);
    tile    = vram_model[map_off];
    row_off = int'(tile) * 16 + int'(by % 8) * 2;
    lo      = vram_model[row_off];
    hi      = vram_model[row_off + 1];
    bit_pos = 7 - int'(bx % 8);
    idx     = {hi[bit_pos], lo[bit_pos]};
    if (!exp_lcdc[0]) begin
      idx = 2'd0;
    end
    return exp_bgp[int'(idx) * 2 +: 2];
  endfunction

  // ==============================
  // Bus and wait tasks
  // ==============================

  // All tasks start and end 1 ns after a rising edge
  task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
    cpu_addr  = addr;
    cpu_wdata = data;
    cpu_we    = 1'b1;
    @(posedge clk);
    #1;
    cpu_we = 1'b0;
  endtask

  task automatic cpu_read(input logic [15:0] addr, output logic [7:0] data);
    cpu_addr = addr;
    cpu_re   = 1'b1;
    @(negedge clk);
    data      = cpu_rdata;
    snap_ly   = ly;
    snap_mode = mode;
    @(posedge clk);
    #1;
    cpu_re = 1'b0;
  endtask

  task automatic wait_mode(input ppu_mode_t m);
    int n;
    n = 0;
    while (mode !== m && n < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (mode !== m) begin
      $display("Timeout while waiting for mode %0d", m);
      stop_run();
    end
  endtask

  task automatic wait_not_transfer();
    int n;
    n = 0;
    while (mode === mode_transfer && n < WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (mode === mode_transfer) begin
      $display("Timeout while waiting for mode 3 to end");
      stop_run();
    end
  endtask

  task automatic wait_frame_done();
    int n;
    n = 0;
    do begin
      @(posedge clk);
      #1;
      n++;
    end while (frame_done !== 1'b1 && n < FRAME_LIMIT);
    if (frame_done !== 1'b1) begin
      $display("Timeout while waiting for frame_done");
      stop_run();
    end
  endtask

  task automatic vram_write(input logic [12:0] off, input logic [7:0] data);
    wait_not_transfer();
    cpu_write(VRAM_BASE + {3'b000, off}, data);
    vram_model[off] = data;
  endtask

  // Register changes land in vblank so a whole frame sees them
  task automatic set_regs(input logic [7:0] scx_v, input logic [7:0] scy_v,
                          input logic [7:0] bgp_v, input logic [7:0] lcdc_v);
    wait_mode(mode_vblank);
    cpu_write(SCX_ADDR, scx_v);
    cpu_write(SCY_ADDR, scy_v);
    cpu_write(BGP_ADDR, bgp_v);
    cpu_write(LCDC_ADDR, lcdc_v);
    exp_scx  = scx_v;
    exp_scy  = scy_v;
    exp_bgp  = bgp_v;
    exp_lcdc = lcdc_v;
  endtask

  // One full frame with pixel checking and line sequence checks
  task automatic capture_frame(input string name);
    int         cycles;
    int         max_ly;
    logic [7:0] prev_ly;
    wait_frame_done();
    test_name = name;
    for (int i = 0; i < SCREEN_H; i++) begin
      line_cnt[i] = 0;
    end
    pix_seen = 0;
    cmp_on  = 1'b1;
    cycles  = 0;
    max_ly  = 0;
    prev_ly = ly;
    do begin
      @(posedge clk);
      #1;
      cycles++;
      if (int'(ly) > max_ly) begin
        max_ly = ly;
      end
      check_value({name, " ly step"}, 1, (ly == prev_ly) || (ly == 8'(prev_ly + 1)) ||
                  (ly == 8'd0 && prev_ly == 8'(LAST_LINE)));
      check_value({name, " vblank mode"}, ly >= SCREEN_H, mode == mode_vblank);
      check_value({name, " pixel in vblank"}, 0, pix_valid && mode == mode_vblank);
      prev_ly = ly;
    end while (frame_done !== 1'b1 && cycles < FRAME_LIMIT);
    cmp_on = 1'b0;
    if (frame_done !== 1'b1) begin
      $display("Timeout while waiting for the end of frame in %s", name);
      stop_run();
    end
    check_value({name, " frame length"}, FRAME_CYCLES, cycles);
    check_value({name, " last line"}, LAST_LINE, max_ly);
    for (int i = 0; i < SCREEN_H; i++) begin
      check_value($sformatf("%s pixels on line %0d", name, i), SCREEN_W, line_cnt[i]);
    end
  endtask

  // ==============================
  // Pixel comparison
  // ==============================

  // Pixels arrive line by line, left to right
  initial begin : compare_pixels
    logic [1:0] want;
    int         want_x;
    int         want_y;
    forever begin
      @(negedge clk);
      if (cmp_on && pix_valid) begin
        want_x = pix_seen % SCREEN_W;
        want_y = pix_seen / SCREEN_W;
        check_value({test_name, " pixel count"}, 1, want_y < SCREEN_H);
        check_value($sformatf("%s y of pixel %0d", test_name, pix_seen), want_y, pix_y);
        check_value($sformatf("%s x order on line %0d", test_name, want_y),
                    want_x, pix_x);
        want = expected_color(want_x, want_y);
        check_value($sformatf("%s color at (%0d,%0d)", test_name, want_x, want_y),
                    want, pix_color);
        line_cnt[want_y]++;
        pix_seen++;
      end
    end
  end

  // ==============================
  // Main sequence
  // ==============================

  initial begin : main_seq
    logic [7:0] rd;
    logic       saw_match;
    cpu_addr  = 16'h0000;
    cpu_wdata = 8'h00;
    cpu_we    = 1'b0;
    cpu_re    = 1'b0;
    reset     = 1'b1;
    cmp_on    = 1'b0;
    pix_seen  = 0;
    err_count = 0;
    test_name = "reset";
    exp_scx   = 8'h00;
    exp_scy   = 8'h00;
    exp_bgp   = 8'hE4;
    exp_lcdc  = 8'h91;
    void'($urandom(7685));
    repeat (3) @(posedge clk);
    #1;
    reset = 1'b0;

    // Reset values
    check_value("reset mode", mode_oam_scan, mode);
    check_value("reset ly", 0, ly);
    check_value("reset pix_valid", 0, pix_valid);
    check_value("reset frame_done", 0, frame_done);
    cpu_read(LCDC_ADDR, rd);
    check_value("reset LCDC", 8'h91, rd);
    cpu_read(BGP_ADDR, rd);
    check_value("reset BGP", 8'hE4, rd);

    // Register read back
    cpu_write(SCX_ADDR, 8'h12);
    cpu_read(SCX_ADDR, rd);
    check_value("SCX read back", 8'h12, rd);
    cpu_write(SCY_ADDR, 8'h34);
    cpu_read(SCY_ADDR, rd);
    check_value("SCY read back", 8'h34, rd);
    cpu_write(LYC_ADDR, 8'h56);
    cpu_read(LYC_ADDR, rd);
    check_value("LYC read back", 8'h56, rd);
    cpu_write(BGP_ADDR, 8'h9C);
    cpu_read(BGP_ADDR, rd);
    check_value("BGP read back", 8'h9C, rd);
    cpu_write(LY_ADDR, 8'hA7);
    cpu_read(LY_ADDR, rd);
    check_value("LY read-only", snap_ly, rd);
    cpu_read(16'hFF46, rd);
    check_value("unmapped FF46", 8'hFF, rd);
    cpu_read(16'h0000, rd);
    check_value("unmapped 0000", 8'hFF, rd);
    cpu_read(16'hA000, rd);
    check_value("unmapped A000", 8'hFF, rd);

    // STAT over a whole frame, LYC match on line 3
    cpu_write(LYC_ADDR, 8'd3);
    saw_match = 1'b0;
    for (int i = 0; i < FRAME_CYCLES + 64; i++) begin
      cpu_read(STAT_ADDR, rd);
      check_value("STAT mode bits", snap_mode, rd[1:0]);
      check_value("STAT LYC match", snap_ly == 8'd3, rd[2]);
      if (rd[2]) begin
        saw_match = 1'b1;
      end
    end
    check_value("STAT match seen", 1, saw_match);
    $display("Register checks done");

    // VRAM access gating in mode 3
    vram_write(13'h1F00, 8'h5A);
    wait_mode(mode_hblank);
    cpu_read(VRAM_BASE + 16'h1F00, rd);
    check_value("VRAM write sticks", 8'h5A, rd);
    wait_mode(mode_transfer);
    cpu_write(VRAM_BASE + 16'h1F00, 8'hA5);
    wait_mode(mode_transfer);
    cpu_read(VRAM_BASE + 16'h1F00, rd);
    check_value("VRAM read in mode 3", 8'hFF, rd);
    wait_mode(mode_hblank);
    cpu_read(VRAM_BASE + 16'h1F00, rd);
    check_value("VRAM write in mode 3 ignored", 8'h5A, rd);
    $display("VRAM access checks done");

    // Random tile data and tile map
    for (int a = 0; a < 'h1000; a++) begin
      vram_write(13'(a), 8'($urandom));
    end
    for (int a = 'h1800; a < 'h1C00; a++) begin
      vram_write(13'(a), 8'($urandom));
    end
    $display("VRAM filled with random tiles");

    set_regs(8'd0, 8'd0, 8'hE4, 8'h91);
    capture_frame("random tiles");
    set_regs(8'd3, 8'd5, 8'h1B, 8'h91);
    capture_frame("scroll 3,5 palette 1B");
    set_regs(8'd3, 8'd5, 8'h1B, 8'h90);
    capture_frame("background off");

    if (err_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* ppu_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module ppu_timing #(
  parameter int SCREEN_H      = 16,
  parameter int DOTS_PER_LINE = 128,
  parameter int OAM_DOTS      = 20,
  parameter int VBLANK_LINES  = 2
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               line_done,
  output ppu_pkg::ppu_mode_t mode,
  output logic [7:0]         ly,
  output logic               xfer_start,
  output logic               frame_done
);
  import ppu_pkg::*;

  localparam int DOT_W = $clog2(DOTS_PER_LINE);

  localparam logic [DOT_W-1:0] LAST_DOT  = DOT_W'(DOTS_PER_LINE - 1);
  localparam logic [DOT_W-1:0] OAM_LAST  = DOT_W'(OAM_DOTS - 1);
  localparam logic [7:0]       LAST_VIS  = 8'(SCREEN_H - 1);
  localparam logic [7:0]       LAST_LINE = 8'(SCREEN_H + VBLANK_LINES - 1);

  logic [DOT_W-1:0] dot;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dot        <= '0;
      ly         <= 8'd0;
      mode       <= mode_oam_scan;
      xfer_start <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      xfer_start <= 1'b0;
      frame_done <= 1'b0;
      if (dot == LAST_DOT) begin
        // Line wrap, pick the mode of the next line
        dot <= '0;
        if (ly == LAST_LINE) begin
          ly         <= 8'd0;
          mode       <= mode_oam_scan;
          frame_done <= 1'b1;
        end else begin
          ly   <= ly + 8'd1;
          mode <= (ly >= LAST_VIS) ? mode_vblank : mode_oam_scan;
        end
      end else begin
        dot <= dot + 1'b1;
        case (mode)
          mode_oam_scan: begin
            if (dot == OAM_LAST) begin
              mode       <= mode_transfer;
              xfer_start <= 1'b1;
            end
          end
          // Variable length, ends when the last pixel is out
          mode_transfer: begin
            if (line_done) begin
              mode <= mode_hblank;
            end
          end
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* ppu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ppu_top #(
  parameter int SCREEN_W      = 32,
  parameter int SCREEN_H      = 16,
  parameter int DOTS_PER_LINE = 128,
  parameter int OAM_DOTS      = 20,
  parameter int VBLANK_LINES  = 2
) (
  input  logic               clk,
  input  logic               reset,
  input  logic [15:0]        cpu_addr,
  input  logic [7:0]         cpu_wdata,
  input  logic               cpu_we,
  input  logic               cpu_re,
  output logic [7:0]         cpu_rdata,
  output ppu_pkg::ppu_mode_t mode,
  output logic [7:0]         ly,
  output logic               frame_done,
  output logic               pix_valid,
  output logic [7:0]         pix_x,
  output logic [7:0]         pix_y,
  output logic [1:0]         pix_color
);
  import ppu_pkg::*;

  logic        xfer_start;
  logic        line_done;
  logic [7:0]  scx;
  logic [7:0]  scy;
  logic [7:0]  bgp;
  logic        bg_enable;
  logic [12:0] rd_addr;
  logic [7:0]  rd_data;
  logic        pop_en;
  logic        empty;
  color_idx_t  pop_px;

  fifo_push_if push_if ();

  // Each transfer starts with an empty FIFO
  assign push_if.flush = xfer_start;

  ppu_timing #(
    .SCREEN_H      (SCREEN_H),
    .DOTS_PER_LINE (DOTS_PER_LINE),
    .OAM_DOTS      (OAM_DOTS),
    .VBLANK_LINES  (VBLANK_LINES)
  ) ppu_timing_inst (
    .clk        (clk),
    .reset      (reset),
    .line_done  (line_done),
    .mode       (mode),
    .ly         (ly),
    .xfer_start (xfer_start),
    .frame_done (frame_done)
  );

  ppu_regs_vram ppu_regs_vram_inst (
    .clk       (clk),
    .reset     (reset),
    .cpu_addr  (cpu_addr),
    .cpu_wdata (cpu_wdata),
    .cpu_we    (cpu_we),
    .cpu_re    (cpu_re),
    .cpu_rdata (cpu_rdata),
    .mode      (mode),
    .ly        (ly),
    .scx       (scx),
    .scy       (scy),
    .bgp       (bgp),
    .bg_enable (bg_enable),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

  bg_fetcher #(
    .SCREEN_W (SCREEN_W)
  ) bg_fetcher_inst (
    .clk     (clk),
    .reset   (reset),
    .mode    (mode),
    .ly      (ly),
    .scx     (scx),
    .scy     (scy),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .push    (push_if.fetcher)
  );

  pixel_fifo pixel_fifo_inst (
    .clk    (clk),
    .reset  (reset),
    .push   (push_if.fifo),
    .pop_en (pop_en),
    .pop_px (pop_px),
    .empty  (empty)
  );

  pixel_out #(
    .SCREEN_W (SCREEN_W)
  ) pixel_out_inst (
    .clk       (clk),
    .reset     (reset),
    .mode      (mode),
    .ly        (ly),
    .scx       (scx),
    .bgp       (bgp),
    .bg_enable (bg_enable),
    .empty     (empty),
    .pop_px    (pop_px),
    .pop_en    (pop_en),
    .pix_valid (pix_valid),
    .pix_x     (pix_x),
    .pix_y     (pix_y),
    .pix_color (pix_color),
    .line_done (line_done)
  );

endmodule

`default_nettype wire

/* sim.f */
ppu_pkg.sv
fifo_push_if.sv
ppu_timing.sv
ppu_regs_vram.sv
bg_fetcher.sv
pixel_fifo.sv
pixel_out.sv
ppu_top.sv
ppu_asserts.sv
ppu_tb.sv
